/* source/fetch_cfg_pkg.sv */
// Fetch unit configuration
// Bus width, restart address and the instruction issued out of reset

package fetch_cfg_pkg;

    // Data and address width, one word
    localparam int unsigned XLEN = 32;

    // Byte offset bits below a word address
    localparam int unsigned WORD_LSB = 2;

    // First fetch address after reset or restart
    localparam logic [XLEN-1:0] START_ADDRESS = 32'h0000_0000;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

endpackage

/* source/fetch_types_pkg.sv */
// Fetch unit types
// Word, word address and the redirect source code

package fetch_types_pkg;

    // One bus word, data or byte address
    typedef logic [fetch_cfg_pkg::XLEN-1:0] word_t;

    // Word address, byte offset dropped
    typedef logic [fetch_cfg_pkg::XLEN-fetch_cfg_pkg::WORD_LSB-1:0] waddr_t;

    // Source of the next fetch address, lowest priority first
    typedef enum logic [2:0] {
        SEL_ADVANCE,
        SEL_BRANCH_PRED,
        SEL_ROLLBACK,
        SEL_JUMP,
        SEL_CTX_SWITCH
    } redirect_sel_e;

endpackage

/* source/fetch_redirect.sv */
// Fetch redirect select
// Picks the next word address by priority and tracks branch prediction rollback

`timescale 1ns/1ps

module fetch_redirect (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          sys_reset_i,
    input  logic                          enable_i,

    input  logic                          ctx_switch_i,
    input  logic                          jump_i,
    input  logic                          bp_take_i,
    input  logic                          jump_rollback_i,
    input  fetch_types_pkg::word_t        ctx_switch_target_i,
    input  fetch_types_pkg::word_t        jump_target_i,
    input  fetch_types_pkg::word_t        bp_target_i,

    input  fetch_types_pkg::waddr_t       cur_waddr_i,
    output fetch_types_pkg::waddr_t       next_waddr_o,
    output fetch_types_pkg::redirect_sel_e redirect_sel_o,
    output logic                          bp_rollback_o
);

    fetch_types_pkg::waddr_t advance_waddr;
    fetch_types_pkg::waddr_t rollback_waddr;
    logic                    rollback_r;

    assign advance_waddr = cur_waddr_i + fetch_types_pkg::waddr_t'(1);

    //////////////////////////////
    // Redirect priority
    //////////////////////////////

    // Context switch wins, then execute jump, then rollback, then prediction
    always_comb begin
        if (ctx_switch_i) begin
            redirect_sel_o = fetch_types_pkg::SEL_CTX_SWITCH;
            next_waddr_o   = ctx_switch_target_i[fetch_cfg_pkg::XLEN-1:fetch_cfg_pkg::WORD_LSB];
        end
        else if (jump_i) begin
            redirect_sel_o = fetch_types_pkg::SEL_JUMP;
            next_waddr_o   = jump_target_i[fetch_cfg_pkg::XLEN-1:fetch_cfg_pkg::WORD_LSB];
        end
        else if (jump_rollback_i) begin
            redirect_sel_o = fetch_types_pkg::SEL_ROLLBACK;
            next_waddr_o   = rollback_waddr;
        end
        else if (enable_i && bp_take_i) begin
            // Decode prediction only counts when the stage advances
            redirect_sel_o = fetch_types_pkg::SEL_BRANCH_PRED;
            next_waddr_o   = bp_target_i[fetch_cfg_pkg::XLEN-1:fetch_cfg_pkg::WORD_LSB];
        end
        else begin
            redirect_sel_o = fetch_types_pkg::SEL_ADVANCE;
            next_waddr_o   = advance_waddr;
        end
    end

    //////////////////////////////
    // Rollback tracking
    //////////////////////////////

    // Word after the fetch address current at the accepted prediction
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rollback_waddr <= fetch_cfg_pkg::START_ADDRESS[fetch_cfg_pkg::XLEN-1:fetch_cfg_pkg::WORD_LSB];
        end
        else if (enable_i && bp_take_i) begin
            rollback_waddr <= advance_waddr;
        end
    end

    // Rollback seen, waiting for the next stage advance
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rollback_r <= 1'b0;
        end
        else if (sys_reset_i) begin
            rollback_r <= 1'b0;
        end
        else if (jump_rollback_i) begin
            rollback_r <= 1'b1;
        end
        else if (enable_i) begin
            rollback_r <= 1'b0;
        end
    end

    // One enabled cycle pulse toward decode
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bp_rollback_o <= 1'b0;
        end
        else if (sys_reset_i) begin
            bp_rollback_o <= 1'b0;
        end
        else if (enable_i) begin
            bp_rollback_o <= rollback_r;
        end
    end

endmodule

/* source/fetch_addr_gen.sv */
// Fetch address generator
// Instruction address register, jump tracking and valid flow control

`timescale 1ns/1ps

module fetch_addr_gen (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          sys_reset_i,
    input  logic                          enable_i,
    input  logic                          busy_i,

    input  fetch_types_pkg::waddr_t       next_waddr_i,
    input  fetch_types_pkg::redirect_sel_e redirect_sel_i,

    output fetch_types_pkg::waddr_t       cur_waddr_o,
    output fetch_types_pkg::word_t        instruction_address_o,
    output fetch_types_pkg::word_t        issue_pc_o,
    output logic                          jumping_o,
    output logic                          valid_o
);

    logic jumped;
    logic rollback;
    logic advance;
    logic jumped_r;
    logic busy_r;

    // Rollback reloads the address but is not counted as a jump
    assign jumped   = (redirect_sel_i == fetch_types_pkg::SEL_CTX_SWITCH) ||
                      (redirect_sel_i == fetch_types_pkg::SEL_JUMP) ||
                      (redirect_sel_i == fetch_types_pkg::SEL_BRANCH_PRED);
    assign rollback = (redirect_sel_i == fetch_types_pkg::SEL_ROLLBACK);
    assign advance  = enable_i && !busy_i;

    //////////////////////////////
    // Address register
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cur_waddr_o <= fetch_cfg_pkg::START_ADDRESS[fetch_cfg_pkg::XLEN-1:fetch_cfg_pkg::WORD_LSB];
        end
        else if (sys_reset_i) begin
            cur_waddr_o <= fetch_cfg_pkg::START_ADDRESS[fetch_cfg_pkg::XLEN-1:fetch_cfg_pkg::WORD_LSB];
        end
        else if (jumped || rollback || advance) begin
            cur_waddr_o <= next_waddr_i;
        end
    end

    assign instruction_address_o = {cur_waddr_o, {fetch_cfg_pkg::WORD_LSB{1'b0}}};

    // Registered bus address that lines up with the returning data
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_pc_o <= fetch_cfg_pkg::START_ADDRESS;
        end
        else if (jumped_r || enable_i) begin
            issue_pc_o <= instruction_address_o;
        end
    end

    //////////////////////////////
    // Jump tracking
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_r <= 1'b1;
        end
        else if (sys_reset_i) begin
            jumped_r <= 1'b1;
        end
        else if (jumped) begin
            jumped_r <= 1'b1;
        end
        else if (enable_i || rollback) begin
            jumped_r <= 1'b0;
        end
    end

    // Marks the issued word as one to discard
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumping_o <= 1'b1;
        end
        else if (sys_reset_i) begin
            jumping_o <= 1'b1;
        end
        else if (jumped || (jumped_r && !rollback)) begin
            jumping_o <= 1'b1;
        end
        else if (enable_i || rollback) begin
            jumping_o <= 1'b0;
        end
    end

    //////////////////////////////
    // Valid flow control
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_r  <= 1'b0;
            valid_o <= 1'b0;
        end
        else if (sys_reset_i) begin
            busy_r  <= 1'b0;
            valid_o <= 1'b0;
        end
        else if (enable_i) begin
            busy_r  <= busy_i;
            valid_o <= !busy_r;
        end
    end

endmodule

/* source/fetch_inst_out.sv */
// Fetch instruction output
// Holds data that arrives during a stall and issues each word with its PC

`timescale 1ns/1ps

module fetch_inst_out (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   sys_reset_i,
    input  logic                   enable_i,
    input  logic                   busy_i,

    input  fetch_types_pkg::word_t instruction_data_i,
    input  fetch_types_pkg::word_t issue_pc_i,

    output fetch_types_pkg::word_t instruction_o,
    output fetch_types_pkg::word_t pc_o
);

    logic                   fetched;
    fetch_types_pkg::word_t idata_held;
    fetch_types_pkg::word_t idata_sel;

    //////////////////////////////
    // Data capture
    //////////////////////////////

    // Memory answers one cycle after an accepted address
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fetched <= 1'b0;
        end
        else begin
            fetched <= enable_i && !busy_i;
        end
    end

    // Keep the word if it shows up while the stage is stalled
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idata_held <= fetch_cfg_pkg::NOP_INSTR;
        end
        else if (!enable_i && fetched) begin
            idata_held <= instruction_data_i;
        end
    end

    assign idata_sel = fetched ? instruction_data_i : idata_held;

    //////////////////////////////
    // Issue
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instruction_o <= fetch_cfg_pkg::NOP_INSTR;
        end
        else if (sys_reset_i) begin
            instruction_o <= fetch_cfg_pkg::NOP_INSTR;
        end
        else if (enable_i) begin
            instruction_o <= idata_sel;
        end
    end

    // PC moves together with the instruction
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_o <= fetch_cfg_pkg::START_ADDRESS;
        end
        else if (sys_reset_i) begin
            pc_o <= fetch_cfg_pkg::START_ADDRESS;
        end
        else if (enable_i) begin
            pc_o <= issue_pc_i;
        end
    end

endmodule

/* source/fetch_top.sv */
// Instruction fetch unit top
// Redirect select, address generation and instruction output

`timescale 1ns/1ps

module fetch_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   sys_reset_i,
    input  logic                   enable_i,
    input  logic                   busy_i,

    // Redirect requests from the core
    input  logic                   ctx_switch_i,
    input  logic                   jump_i,
    input  logic                   bp_take_i,
    input  logic                   jump_rollback_i,
    input  fetch_types_pkg::word_t ctx_switch_target_i,
    input  fetch_types_pkg::word_t jump_target_i,
    input  fetch_types_pkg::word_t bp_target_i,

    // Instruction memory
    output fetch_types_pkg::word_t instruction_address_o,
    input  fetch_types_pkg::word_t instruction_data_i,

    // Toward decode
    output fetch_types_pkg::word_t instruction_o,
    output fetch_types_pkg::word_t pc_o,
    output logic                   jumping_o,
    output logic                   valid_o,
    output logic                   bp_rollback_o
);

    fetch_types_pkg::waddr_t        cur_waddr;
    fetch_types_pkg::waddr_t        next_waddr;
    fetch_types_pkg::redirect_sel_e redirect_sel;
    fetch_types_pkg::word_t         issue_pc;

    //////////////////////////////
    // Stages
    //////////////////////////////

    fetch_redirect redirect_i (
        .clk                 (clk),
        .reset_n             (reset_n),
        .sys_reset_i         (sys_reset_i),
        .enable_i            (enable_i),
        .ctx_switch_i        (ctx_switch_i),
        .jump_i              (jump_i),
        .bp_take_i           (bp_take_i),
        .jump_rollback_i     (jump_rollback_i),
        .ctx_switch_target_i (ctx_switch_target_i),
        .jump_target_i       (jump_target_i),
        .bp_target_i         (bp_target_i),
        .cur_waddr_i         (cur_waddr),
        .next_waddr_o        (next_waddr),
        .redirect_sel_o      (redirect_sel),
        .bp_rollback_o       (bp_rollback_o)
    );

    fetch_addr_gen addr_gen_i (
        .clk                   (clk),
        .reset_n               (reset_n),
        .sys_reset_i           (sys_reset_i),
        .enable_i              (enable_i),
        .busy_i                (busy_i),
        .next_waddr_i          (next_waddr),
        .redirect_sel_i        (redirect_sel),
        .cur_waddr_o           (cur_waddr),
        .instruction_address_o (instruction_address_o),
        .issue_pc_o            (issue_pc),
        .jumping_o             (jumping_o),
        .valid_o               (valid_o)
    );

    // Pairs returning data with the address that fetched it
    fetch_inst_out inst_out_i (
        .clk                (clk),
        .reset_n            (reset_n),
        .sys_reset_i        (sys_reset_i),
        .enable_i           (enable_i),
        .busy_i             (busy_i),
        .instruction_data_i (instruction_data_i),
        .issue_pc_i         (issue_pc),
        .instruction_o      (instruction_o),
        .pc_o               (pc_o)
    );

endmodule

/* sim/fetch_tb_util.svh */
// Fetch testbench helpers
// LFSR stimulus source, memory contents and the address reference model

`ifndef FETCH_TB_UTIL_SVH
`define FETCH_TB_UTIL_SVH

// Fibonacci LFSR with taps at 32 22 2 and 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    lfsr_next = {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// Steps the LFSR once per bit, newest bit in the LSB
function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] bits;
    int unsigned i;
    bits = 32'd0;
    for (i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        bits       = {bits[30:0], lfsr_state[0]};
    end
    take_bits = bits;
endfunction

// Memory contents, every address bit takes part
function automatic logic [31:0] mem_word(input logic [31:0] addr);
    mem_word = (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h0f0f_5a5a;
endfunction

function automatic logic [31:0] word_align(input logic [31:0] addr);
    word_align = {addr[31:2], 2'b00};
endfunction

// Sources that reload the address and raise jumping_o
function automatic logic is_redirect(input logic ctx, jmp, roll, en, bp);
    is_redirect = ctx || jmp || (!roll && en && bp);
endfunction

// Next fetch byte address after one clock edge
function automatic logic [31:0] model_next_addr(
    input logic [31:0] cur_addr,
    input logic [31:0] rollback_addr,
    input logic        restart,
    input logic        en,
    input logic        stall,
    input logic        ctx,
    input logic [31:0] ctx_target,
    input logic        jmp,
    input logic [31:0] jmp_target,
    input logic        bp,
    input logic [31:0] bp_target,
    input logic        roll
);
    if (restart) model_next_addr = fetch_cfg_pkg::START_ADDRESS;
    else if (ctx) model_next_addr = word_align(ctx_target);
    else if (jmp) model_next_addr = word_align(jmp_target);
    else if (roll) model_next_addr = rollback_addr;
    else if (en && bp) model_next_addr = word_align(bp_target);
    else if (en && !stall) model_next_addr = cur_addr + 32'd4;
    else model_next_addr = cur_addr;
endfunction

`endif

/* sim/fetch_tb.sv */
// Fetch unit testbench
// Random flow control and redirects checked against an address model

`timescale 1ns/1ps

module fetch_tb;

    logic        clk;
    logic        reset_n;
    logic        sys_reset;
    logic        enable;
    logic        busy;
    logic        ctx_switch;
    logic        jump;
    logic        bp_take;
    logic        jump_rollback;
    logic [31:0] ctx_target;
    logic [31:0] jump_target;
    logic [31:0] bp_target;
    logic [31:0] instr_data = 32'h0;
    logic [31:0] instr_addr;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic        jumping;
    logic        valid;
    logic        bp_rollback;

    logic [31:0] lfsr_state;
    logic [31:0] mem_addr = 32'h0;
    logic [31:0] model_addr;
    logic [31:0] model_rb;
    logic        model_busy_r;
    logic        model_valid;
    int          addr_errors;
    int          ctrl_errors;
    int          pair_errors;
    int          wait_errors;
    int          pair_checks;

    `include "fetch_tb_util.svh"

    fetch_top dut_i (
        .clk(clk), .reset_n(reset_n), .sys_reset_i(sys_reset), .enable_i(enable),
        .busy_i(busy), .ctx_switch_i(ctx_switch), .jump_i(jump), .bp_take_i(bp_take),
        .jump_rollback_i(jump_rollback), .ctx_switch_target_i(ctx_target),
        .jump_target_i(jump_target), .bp_target_i(bp_target),
        .instruction_address_o(instr_addr), .instruction_data_i(instr_data),
        .instruction_o(instruction), .pc_o(pc), .jumping_o(jumping), .valid_o(valid),
        .bp_rollback_o(bp_rollback)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Memory answers the address sampled at the previous rising edge
    always @(negedge clk) begin
        instr_data = mem_word(mem_addr);
        mem_addr   = instr_addr;
    end

    // Error classes are 0 for address, 1 for control and any other for pairing
    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual,
                                   input int kind);
        $display("mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
        case (kind)
            0: addr_errors++;
            1: ctrl_errors++;
            default: pair_errors++;
        endcase
    endtask

    task automatic report_timeout(input string test, input string what);
        $display("%s: timed out waiting for %s", test, what);
        wait_errors++;
    endtask

    task automatic clear_requests();
        sys_reset     = 1'b0;
        ctx_switch    = 1'b0;
        jump          = 1'b0;
        bp_take       = 1'b0;
        jump_rollback = 1'b0;
    endtask

    task automatic randomize_flow();
        enable = (take_bits(2) != 32'd0);
        busy   = (take_bits(2) == 32'd0);
    endtask

    // Applies the inputs set at this falling edge and checks outputs at the next one
    task automatic step_cycle(input string test);
        logic [31:0] exp_addr;
        logic        exp_jump;
        logic        exp_valid;
        logic        was_enabled;
        exp_addr    = model_next_addr(model_addr, model_rb, sys_reset, enable, busy,
                                      ctx_switch, ctx_target, jump, jump_target,
                                      bp_take, bp_target, jump_rollback);
        exp_jump    = sys_reset || is_redirect(ctx_switch, jump, jump_rollback, enable, bp_take);
        was_enabled = enable;
        if (enable && bp_take) model_rb = model_addr + 32'd4;
        // Valid is the inverse of busy as registered on the previous enabled edge
        exp_valid = model_valid;
        if (sys_reset) begin
            exp_valid    = 1'b0;
            model_busy_r = 1'b0;
        end
        else if (enable) begin
            exp_valid    = !model_busy_r;
            model_busy_r = busy;
        end
        model_valid = exp_valid;
        @(posedge clk);
        @(negedge clk);
        model_addr = exp_addr;
        if (instr_addr !== exp_addr)
            report_mismatch(test, "instruction_address_o", exp_addr, instr_addr, 0);
        if (exp_jump && jumping !== 1'b1)
            report_mismatch(test, "jumping_o", 32'd1, {31'd0, jumping}, 1);
        if (valid !== exp_valid)
            report_mismatch(test, "valid_o", {31'd0, exp_valid}, {31'd0, valid}, 1);
        if (was_enabled && valid && !jumping) begin
            pair_checks++;
            if (instruction !== mem_word(pc))
                report_mismatch(test, "instruction_o", mem_word(pc), instruction, 2);
        end
    endtask

    task automatic check_reset_outputs(input string test);
        if (instr_addr !== fetch_cfg_pkg::START_ADDRESS)
            report_mismatch(test, "instruction_address_o", fetch_cfg_pkg::START_ADDRESS,
                            instr_addr, 0);
        if (instruction !== fetch_cfg_pkg::NOP_INSTR)
            report_mismatch(test, "instruction_o", fetch_cfg_pkg::NOP_INSTR, instruction, 1);
        if (jumping !== 1'b1)
            report_mismatch(test, "jumping_o", 32'd1, {31'd0, jumping}, 1);
        if (valid !== 1'b0)
            report_mismatch(test, "valid_o", 32'd0, {31'd0, valid}, 1);
        if (bp_rollback !== 1'b0)
            report_mismatch(test, "bp_rollback_o", 32'd0, {31'd0, bp_rollback}, 1);
    endtask

    task automatic pulse_restart(input string test);
        clear_requests();
        randomize_flow();
        sys_reset = 1'b1;
        step_cycle(test);
        sys_reset = 1'b0;
        check_reset_outputs(test);
    endtask

    initial begin
        int          i;
        int          trial;
        int          waited;
        int          extra;
        logic [31:0] saved_rb;
        lfsr_state   = 32'hf75e_ee87;
        addr_errors  = 0;
        ctrl_errors  = 0;
        pair_errors  = 0;
        wait_errors  = 0;
        pair_checks  = 0;
        reset_n      = 1'b0;
        enable       = 1'b0;
        busy         = 1'b0;
        ctx_target   = 32'h0;
        jump_target  = 32'h0;
        bp_target    = 32'h0;
        clear_requests();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n      = 1'b1;
        model_addr   = fetch_cfg_pkg::START_ADDRESS;
        model_rb     = fetch_cfg_pkg::START_ADDRESS;
        model_busy_r = 1'b0;
        model_valid  = 1'b0;
        check_reset_outputs("reset");

        for (i = 0; i < 150; i++) begin
            randomize_flow();
            step_cycle("sequential");
        end
        pulse_restart("restart");

        //////////////////////////////
        // Redirect priority
        //////////////////////////////
        for (i = 0; i < 200; i++) begin
            randomize_flow();
            ctx_switch  = (take_bits(3) == 32'd0);
            jump        = (take_bits(3) == 32'd0);
            bp_take     = (take_bits(2) == 32'd0);
            ctx_target  = take_bits(32);
            jump_target = take_bits(32);
            bp_target   = take_bits(32);
            step_cycle("redirect");
        end
        clear_requests();

        //////////////////////////////
        // Rollback
        //////////////////////////////
        for (trial = 0; trial < 16; trial++) begin
            enable    = 1'b1;
            busy      = (take_bits(2) == 32'd0);
            bp_take   = 1'b1;
            bp_target = take_bits(32);
            saved_rb  = model_addr + 32'd4;
            step_cycle("rollback");
            clear_requests();
            // Let the predicted jump drain before rolling back
            waited = 0;
            while (jumping && waited < 32) begin
                randomize_flow();
                step_cycle("rollback");
                waited++;
            end
            if (jumping) report_timeout("rollback", "jumping_o to clear");
            extra = int'(take_bits(2));
            for (i = 0; i < extra; i++) begin
                randomize_flow();
                step_cycle("rollback");
            end
            enable        = 1'b1;
            busy          = (take_bits(2) == 32'd0);
            jump_rollback = 1'b1;
            step_cycle("rollback");
            jump_rollback = 1'b0;
            if (instr_addr !== saved_rb)
                report_mismatch("rollback", "instruction_address_o", saved_rb, instr_addr, 0);
            waited = 0;
            while (!bp_rollback && waited < 32) begin
                randomize_flow();
                step_cycle("rollback");
                waited++;
            end
            if (!bp_rollback) report_timeout("rollback", "bp_rollback_o");
        end
        pulse_restart("restart_end");

        if (pair_checks == 0) begin
            $display("pairing: no instruction and PC pair was ever compared");
            pair_errors++;
        end

        $display("Errors: address %0d, control %0d, pairing %0d, timeout %0d (%0d pair checks)",
                 addr_errors, ctrl_errors, pair_errors, wait_errors, pair_checks);
        if (addr_errors + ctrl_errors + pair_errors + wait_errors == 0) begin
            $display("All checks passed");
        end
        else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+sim
source/fetch_cfg_pkg.sv
source/fetch_types_pkg.sv
source/fetch_redirect.sv
source/fetch_addr_gen.sv
source/fetch_inst_out.sv
source/fetch_top.sv
sim/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module fetch_tb \
    -o fetch_tb_sim || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/fetch_tb_sim)"
echo "$sim_out"

echo "$sim_out" | grep -qx "All checks passed" && echo "Result PASS" \
    || { echo "Result FAIL"; exit 1; }
